// ==== vlog.f ====
+incdir+hdl
hdl/spi_types_pkg.sv
hdl/spi_fsm_pkg.sv
hdl/spi_shift_if.sv
hdl/spi_fifo.sv
hdl/spi_ctrl.sv
hdl/spi_datapath.sv
hdl/spi_master.sv
dv/spi_master_assert.sv
dv/spi_master_tb.sv

// ==== Bender.yml ====
package:
  name: spi_master

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/spi_types_pkg.sv
      - hdl/spi_fsm_pkg.sv
      - hdl/spi_shift_if.sv
      - hdl/spi_fifo.sv
      - hdl/spi_ctrl.sv
      - hdl/spi_datapath.sv
      - hdl/spi_master.sv
  - target: simulation
    files:
      - dv/spi_master_assert.sv
      - dv/spi_master_tb.sv

// ==== dv/spi_master_tb.sv ====
`timescale 1ns/1ps

module spi_master_tb;
    import spi_types_pkg::*;

    localparam int WAIT_LIMIT  = 4000;
    localparam int IDLE_WINDOW = 200;

    typedef struct packed {
        spi_byte_t data;
        spi_div_t  div;
        logic      cpha;
        logic      lsb_first;
        spi_byte_t seq;    // wire order with the first bit in [7]
    } row_t;

    logic       clk;
    logic       rst_n;
    spi_byte_t  tx_data;
    logic       tx_valid;
    logic       tx_ready;
    spi_byte_t  rx_data;
    logic       rx_valid;
    logic       rx_ready;
    spi_div_t   div;
    logic       cpha;
    logic       lsb_first;
    spi_level_t tx_level;
    spi_level_t rx_level;
    logic       tx_mark;
    logic       rx_mark;
    logic       sclk;
    logic       cs_n;
    logic       mosi;

    row_t        rows [4];
    spi_byte_t   sent_q [$];
    logic [31:0] lfsr;
    spi_byte_t   cap_bits;
    int          cap_n;
    logic        prev_sclk;
    int          gap;
    int          edge_n;

    // Loopback ties miso to mosi
    spi_master dut0 (.*, .miso(mosi));

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic random_byte(output spi_byte_t b);
        for (int i = 0; i < 8; i++) begin
            b = {b[6:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic expect_eq(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp)
        else abort_run($sformatf("FAIL %s: got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    task automatic wait_cs(input logic level, input string what);
        int n;
        n = 0;
        while (cs_n !== level) begin
            @(negedge clk);
            n++;
            assert (n < WAIT_LIMIT) else abort_run({"timeout waiting for ", what});
        end
    endtask

    // Called on a falling edge and returns on the falling edge after the transfer
    task automatic push_byte(input spi_byte_t b);
        int n;
        n = 0;
        tx_data  = b;
        tx_valid = 1'b1;
        while (!tx_ready) begin
            @(negedge clk);
            n++;
            assert (n < WAIT_LIMIT) else abort_run("timeout waiting for tx_ready");
        end
        @(negedge clk);
        tx_valid = 1'b0;
        sent_q.push_back(b);
    endtask

    task automatic pop_check();
        int        n;
        spi_byte_t exp;
        n = 0;
        while (!rx_valid) begin
            @(negedge clk);
            n++;
            assert (n < WAIT_LIMIT) else abort_run("timeout waiting for rx_valid");
        end
        assert (sent_q.size() != 0) else abort_run("received a byte that was never sent");
        exp = sent_q.pop_front();
        expect_eq("rx_data", rx_data, exp);
        rx_ready = 1'b1;
        @(negedge clk);
        rx_ready = 1'b0;
    endtask

    // ------------------------------------------------------------------------
    // sclk monitor for captured bits and edge spacing
    // ------------------------------------------------------------------------
    always @(negedge clk) begin
        if (!rst_n) begin
            prev_sclk = 1'b0;
            gap       = 0;
            edge_n    = 0;
        end else begin
            gap++;
            if (sclk !== prev_sclk) begin
                if (edge_n != 0)
                    expect_eq("sclk half-period", gap, int'(div) + 1);
                edge_n++;
                gap = 0;
                // Rising edge captures for cpha 0 and falling for cpha 1
                if (sclk == !cpha) begin
                    cap_bits = {cap_bits[6:0], mosi};
                    cap_n++;
                end
            end
            if (cs_n)
                edge_n = 0;
            prev_sclk = sclk;
            assert (dut0.u_assert.fail_cnt == 0)
            else abort_run("protocol assertion failed on the SPI bus");
        end
    end

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    initial begin
        spi_byte_t b;
        lfsr      = 32'h5ae50bb7;
        rst_n     = 1'b0;
        tx_data   = '0;
        tx_valid  = 1'b0;
        rx_ready  = 1'b0;
        div       = '0;
        cpha      = 1'b0;
        lsb_first = 1'b0;
        tx_level  = 3'd4;
        rx_level  = 3'd3;
        cap_bits  = '0;
        cap_n     = 0;
        rows[0] = '{8'h12, 12'd0, 1'b0, 1'b0, 8'h12};
        rows[1] = '{8'hC1, 12'd1, 1'b1, 1'b0, 8'hC1};
        rows[2] = '{8'h5E, 12'd2, 1'b0, 1'b1, 8'h7A};
        rows[3] = '{8'h96, 12'd3, 1'b1, 1'b1, 8'h69};

        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        expect_eq("cs_n", cs_n, 1'b1);
        expect_eq("sclk", sclk, 1'b0);
        expect_eq("mosi", mosi, 1'b0);
        expect_eq("rx_valid", rx_valid, 1'b0);
        expect_eq("tx_ready", tx_ready, 1'b1);
        expect_eq("tx_mark", tx_mark, 1'b1);
        expect_eq("rx_mark", rx_mark, 1'b0);

        foreach (rows[i]) begin
            div       = rows[i].div;
            cpha      = rows[i].cpha;
            lsb_first = rows[i].lsb_first;
            cap_n     = 0;
            push_byte(rows[i].data);
            pop_check();
            expect_eq("mosi bits", cap_bits, rows[i].seq);
            expect_eq("mosi bit count", cap_n, 8);
            wait_cs(1'b1, "end of frame");
        end

        // Fill the receive FIFO one frame at a time while the transmit side stays empty
        div      = 12'd1;
        cpha     = 1'b1;
        tx_level = 3'd5;
        for (int k = 1; k <= 8; k++) begin
            random_byte(b);
            push_byte(b);
            wait_cs(1'b0, "frame start");
            wait_cs(1'b1, "frame end");
            expect_eq("rx_mark", rx_mark, k > int'(rx_level));
            expect_eq("tx_mark", tx_mark, 0 < int'(tx_level));
        end

        // Receive FIFO is full so bytes pile up on the transmit side
        for (int j = 1; j <= 8; j++) begin
            random_byte(b);
            push_byte(b);
            expect_eq("cs_n", cs_n, 1'b1);
            expect_eq("tx_mark", tx_mark, j < int'(tx_level));
            expect_eq("rx_mark", rx_mark, 8 > int'(rx_level));
        end
        expect_eq("tx_ready", tx_ready, 1'b0);
        repeat (IDLE_WINDOW) begin
            @(negedge clk);
            assert (cs_n) else abort_run("a frame started while the receive FIFO was full");
            expect_eq("sclk", sclk, 1'b0);
            expect_eq("mosi", mosi, 1'b0);
        end

        while (sent_q.size() != 0)
            pop_check();
        wait_cs(1'b1, "end of the last frame");

        if (dut0.u_assert.fail_cnt == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            abort_run("protocol assertion failed on the SPI bus");
        end
    end

endmodule

// ==== dv/spi_master_assert.sv ====
`timescale 1ns/1ps

module spi_master_assert (
    input logic clk,
    input logic rst_n,
    input logic cpha,
    input logic sclk,
    input logic cs_n,
    input logic mosi,
    input logic rx_valid
);

    int unsigned fail_cnt = 0;
    logic        frame_seen;

    // Set once chip select has gone low
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            frame_seen <= 1'b0;
        else if (!cs_n)
            frame_seen <= 1'b1;
    end

    a_sclk_idle: assert property (@(posedge clk) disable iff (!rst_n)
        cs_n |-> $stable(sclk))
    else begin
        $error("sclk toggled while cs_n was high");
        fail_cnt++;
    end

    // Capture edge is rising for cpha 0 and falling for cpha 1
    a_mosi_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (sclk != $past(sclk)) && (sclk == !cpha) |-> $stable(mosi))
    else begin
        $error("mosi changed on a capture edge of sclk");
        fail_cnt++;
    end

    a_rx_after_frame: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(rx_valid) |-> frame_seen)
    else begin
        $error("rx_valid rose before any frame");
        fail_cnt++;
    end

endmodule

bind spi_master spi_master_assert u_assert (.*);

// ==== hdl/spi_master.sv ====
`timescale 1ns/1ps

module spi_master (
    input  logic                      clk,
    input  logic                      rst_n,

    // Host transmit side
    input  spi_types_pkg::spi_byte_t  tx_data,
    input  logic                      tx_valid,
    output logic                      tx_ready,

    // Host receive side
    output spi_types_pkg::spi_byte_t  rx_data,
    output logic                      rx_valid,
    input  logic                      rx_ready,

    // Configuration
    input  spi_types_pkg::spi_div_t   div,
    input  logic                      cpha,
    input  logic                      lsb_first,
    input  spi_types_pkg::spi_level_t tx_level,
    input  spi_types_pkg::spi_level_t rx_level,
    output logic                      tx_mark,
    output logic                      rx_mark,

    // Serial bus
    output logic                      sclk,
    output logic                      cs_n,
    output logic                      mosi,
    input  logic                      miso
);

    logic tx_avail;
    logic rx_room;

    spi_shift_if shift_bus ();

    spi_ctrl u_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .div      (div),
        .cpha     (cpha),
        .tx_avail (tx_avail),
        .rx_room  (rx_room),
        .sclk     (sclk),
        .cs_n     (cs_n),
        .shift    (shift_bus.ctrl)
    );

    spi_datapath u_dp (
        .clk       (clk),
        .rst_n     (rst_n),
        .lsb_first (lsb_first),
        .miso      (miso),
        .mosi      (mosi),
        .tx_data   (tx_data),
        .tx_valid  (tx_valid),
        .tx_ready  (tx_ready),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid),
        .rx_ready  (rx_ready),
        .tx_level  (tx_level),
        .rx_level  (rx_level),
        .tx_mark   (tx_mark),
        .rx_mark   (rx_mark),
        .tx_avail  (tx_avail),
        .rx_room   (rx_room),
        .shift     (shift_bus.dp)
    );

endmodule

// ==== hdl/spi_datapath.sv ====
`timescale 1ns/1ps

module spi_datapath (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      lsb_first,
    input  logic                      miso,
    output logic                      mosi,
    input  spi_types_pkg::spi_byte_t  tx_data,
    input  logic                      tx_valid,
    output logic                      tx_ready,
    output spi_types_pkg::spi_byte_t  rx_data,
    output logic                      rx_valid,
    input  logic                      rx_ready,
    input  spi_types_pkg::spi_level_t tx_level,
    input  spi_types_pkg::spi_level_t rx_level,
    output logic                      tx_mark,
    output logic                      rx_mark,
    output logic                      tx_avail,
    output logic                      rx_room,
    spi_shift_if.dp                   shift
);
    import spi_types_pkg::*;

    spi_byte_t tx_head;
    spi_byte_t tx_sr;
    spi_byte_t rx_sr;
    spi_cnt_t  tx_cnt;
    spi_cnt_t  rx_cnt;

    // ------------------------------------------------------------------------
    // Transmit shifter
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            mosi <= 1'b0;
        else if (shift.load)
            mosi <= lsb_first ? tx_head[0] : tx_head[7];
        else if (shift.shift)
            mosi <= lsb_first ? tx_sr[0] : tx_sr[7];
        else if (shift.done)
            mosi <= 1'b0;  // back to idle low between frames
    end

    // Remaining bits stay aligned to the outgoing end
    always_ff @(posedge clk) begin
        if (shift.load)
            tx_sr <= lsb_first ? {1'b0, tx_head[7:1]} : {tx_head[6:0], 1'b0};
        else if (shift.shift)
            tx_sr <= lsb_first ? {1'b0, tx_sr[7:1]} : {tx_sr[6:0], 1'b0};
    end

    // ------------------------------------------------------------------------
    // Receive shifter
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (shift.sample)
            rx_sr <= lsb_first ? {miso, rx_sr[7:1]} : {rx_sr[6:0], miso};
    end

    // Watermarks
    assign tx_mark = (tx_cnt < spi_cnt_t'(tx_level));
    assign rx_mark = (rx_cnt > spi_cnt_t'(rx_level));

    spi_fifo tx_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_data   (tx_data),
        .in_valid  (tx_valid),
        .in_ready  (tx_ready),
        .out_data  (tx_head),
        .out_valid (tx_avail),
        .out_ready (shift.load),
        .count     (tx_cnt)
    );

    spi_fifo rx_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_data   (rx_sr),
        .in_valid  (shift.done),
        .in_ready  (rx_room),
        .out_data  (rx_data),
        .out_valid (rx_valid),
        .out_ready (rx_ready),
        .count     (rx_cnt)
    );

endmodule

// ==== hdl/spi_ctrl.sv ====
`timescale 1ns/1ps

module spi_ctrl (
    input  logic                    clk,
    input  logic                    rst_n,
    input  spi_types_pkg::spi_div_t div,
    input  logic                    cpha,
    input  logic                    tx_avail,
    input  logic                    rx_room,
    output logic                    sclk,
    output logic                    cs_n,
    spi_shift_if.ctrl               shift
);
    import spi_types_pkg::*;
    import spi_fsm_pkg::*;

    spi_state_e state;
    spi_div_t   hp_cnt;
    logic [3:0] edge_cnt;
    logic       done_q;
    logic       tick;
    logic       reload;
    logic       start;
    logic       edge_rise;
    logic       edge_fall;
    logic       last_edge;

    // ------------------------------------------------------------------------
    // Timing strobes
    // ------------------------------------------------------------------------
    assign tick = (hp_cnt == '0);

    // New frame only with a byte to send and room for the reply
    assign start = tx_avail && rx_room &&
                   ((state == SPI_ST_IDLE) || ((state == SPI_ST_GAP) && tick));

    // sclk idles low, so even edge indices rise
    assign edge_rise = (state == SPI_ST_TRANS) && tick && !edge_cnt[0];
    assign edge_fall = (state == SPI_ST_TRANS) && tick && edge_cnt[0];
    assign last_edge = edge_fall && (edge_cnt == 4'd15);

    assign reload = start || (tick && (state != SPI_ST_IDLE) && (state != SPI_ST_GAP));

    assign shift.load   = cpha ? (edge_rise && (edge_cnt == 4'd0)) : start;
    assign shift.sample = cpha ? edge_fall : edge_rise;
    assign shift.shift  = cpha ? (edge_rise && (edge_cnt != 4'd0)) : (edge_fall && !last_edge);
    assign shift.done   = done_q;

    // ------------------------------------------------------------------------
    // Half-period counter
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            hp_cnt <= '0;
        else if (reload)
            hp_cnt <= div;
        else if (!tick)
            hp_cnt <= hp_cnt - 1'b1;
    end

    // Done lands on the first cycle of HOLD, after the last capture
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            done_q <= 1'b0;
        else
            done_q <= last_edge;
    end

    // ------------------------------------------------------------------------
    // Frame FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= SPI_ST_IDLE;
            edge_cnt <= '0;
            sclk     <= 1'b0;
            cs_n     <= 1'b1;
        end else begin
            case (state)
                SPI_ST_IDLE, SPI_ST_GAP: begin
                    if (start) begin
                        state <= SPI_ST_SETUP;
                        cs_n  <= 1'b0;
                    end else if (tick) begin
                        state <= SPI_ST_IDLE;
                    end
                end
                SPI_ST_SETUP: begin
                    if (tick) begin
                        state    <= SPI_ST_TRANS;
                        edge_cnt <= '0;
                    end
                end
                SPI_ST_TRANS: begin
                    // 16 half-periods, one sclk edge at the end of each
                    if (tick) begin
                        sclk     <= ~sclk;
                        edge_cnt <= edge_cnt + 1'b1;
                        if (edge_cnt == 4'd15)
                            state <= SPI_ST_HOLD;
                    end
                end
                SPI_ST_HOLD: begin
                    if (tick) begin
                        state <= SPI_ST_GAP;
                        cs_n  <= 1'b1;
                    end
                end
                default: state <= SPI_ST_IDLE;
            endcase
        end
    end

endmodule

// ==== hdl/spi_fifo.sv ====
`timescale 1ns/1ps
`include "spi_defs.svh"

module spi_fifo (
    input  logic                     clk,
    input  logic                     rst_n,
    input  spi_types_pkg::spi_byte_t in_data,
    input  logic                     in_valid,
    output logic                     in_ready,
    output spi_types_pkg::spi_byte_t out_data,
    output logic                     out_valid,
    input  logic                     out_ready,
    output spi_types_pkg::spi_cnt_t  count
);
    import spi_types_pkg::*;

    localparam int PTR_W = $clog2(`SPI_FIFO_DEPTH);

    spi_byte_t        mem [`SPI_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(`SPI_FIFO_DEPTH - 1))
            return '0;
        return ptr + 1'b1;
    endfunction

    assign in_ready  = (count != spi_cnt_t'(`SPI_FIFO_DEPTH));
    assign out_valid = (count != '0);
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    // Head is visible without read latency
    assign out_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= in_data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= ptr_inc(wr_ptr);
            if (pop)
                rd_ptr <= ptr_inc(rd_ptr);
            // Push and pop together leave the count alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== hdl/spi_shift_if.sv ====
`timescale 1ns/1ps

interface spi_shift_if;

    // Pop tx FIFO head into the shifter, first bit out
    logic load;
    // Capture edge of sclk
    logic sample;
    // Change edge of sclk, next bit out
    logic shift;
    // Byte complete, push rx shifter
    logic done;

    modport ctrl (
        output load, sample, shift, done
    );

    modport dp (
        input load, sample, shift, done
    );

endinterface

// ==== hdl/spi_fsm_pkg.sv ====
package spi_fsm_pkg;

    typedef enum logic [2:0] {
        SPI_ST_IDLE,
        SPI_ST_SETUP,
        SPI_ST_TRANS,
        SPI_ST_HOLD,
        SPI_ST_GAP
    } spi_state_e;

endpackage

// ==== hdl/spi_types_pkg.sv ====
`include "spi_defs.svh"

package spi_types_pkg;

    // One serial frame
    typedef logic [7:0] spi_byte_t;

    typedef logic [`SPI_DIV_W-1:0] spi_div_t;
    typedef logic [`SPI_CNT_W-1:0] spi_cnt_t;

    // Watermark compare level
    typedef logic [2:0] spi_level_t;

endpackage

// ==== hdl/spi_defs.svh ====
`ifndef SPI_DEFS_SVH
`define SPI_DEFS_SVH

// Entries per FIFO
`define SPI_FIFO_DEPTH 8

// Occupancy count, must hold 0 to SPI_FIFO_DEPTH
`define SPI_CNT_W 4

// Divider value, half-period of sclk minus one
`define SPI_DIV_W 12

`endif
